// ==== hw/exec_alu.sv ====
// Integer ALU for the execute stage
// Shared adder, logic ops, single shifter/rotator and comparator
`timescale 1ns/1ns

module exec_alu (
    input  exec_pkg::alu_ctrl_t i_ctrl,
    input  exec_pkg::xlen_t     i_lhs,
    input  exec_pkg::xlen_t     i_rhs,
    output exec_pkg::xlen_t     o_result,
    output exec_pkg::xlen_t     o_sum,
    output logic                o_lt,
    output logic                o_eq
);

    localparam int XL = exec_pkg::XLEN;

    logic                sub_mode;
    exec_pkg::xlen_t     rhs_adj;
    logic [XL:0]         add_full;
    logic                lt_signed;
    logic [4:0]          shamt;
    exec_pkg::xlen_t     lhs_rev;
    exec_pkg::xlen_t     shf_in;
    exec_pkg::xlen_t     shf_hi;
    logic [2*XL-1:0]     shf_wide;
    exec_pkg::xlen_t     shf_out;
    exec_pkg::xlen_t     shf_rev;
    exec_pkg::xlen_t     shf_result;

    // ------------------------------------------------------------------------
    // Adder and comparator
    // ------------------------------------------------------------------------
    assign sub_mode = i_ctrl.op_sub || i_ctrl.compare;
    assign rhs_adj  = sub_mode ? ~i_rhs : i_rhs;        // Two's complement negate
    assign add_full = {1'b0, i_lhs} + {1'b0, rhs_adj} + {{XL{1'b0}}, sub_mode};
    assign o_sum    = add_full[XL-1:0];

    // Signs differ: lhs sign decides, else sign of difference
    assign lt_signed = (i_lhs[XL-1] != i_rhs[XL-1]) ? i_lhs[XL-1] : add_full[XL-1];
    assign o_lt      = i_ctrl.is_unsigned ? !add_full[XL] : lt_signed; // No carry = borrow
    assign o_eq      = (i_lhs == i_rhs);

    // ------------------------------------------------------------------------
    // Shifter, right shift only; left shifts run on the bit-reversed operand
    // ------------------------------------------------------------------------
    assign shamt    = i_rhs[4:0];
    assign lhs_rev  = {<<{i_lhs}};
    assign shf_in   = i_ctrl.shift_left ? lhs_rev : i_lhs;
    assign shf_hi   = i_ctrl.rotate      ? shf_in :            // Wrap for ror
                      i_ctrl.shift_arith ? {XL{i_lhs[XL-1]}} : // Sign fill
                                           '0;
    assign shf_wide = {shf_hi, shf_in} >> shamt;
    assign shf_out  = shf_wide[XL-1:0];
    assign shf_rev  = {<<{shf_out}};
    assign shf_result = i_ctrl.shift_left ? shf_rev : shf_out;

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------
    assign o_result = {XL{i_ctrl.op_add || i_ctrl.op_sub}}     & o_sum           |
                      {XL{i_ctrl.op_xor}}                      & (i_lhs ^ i_rhs) |
                      {XL{i_ctrl.op_or}}                       & (i_lhs | i_rhs) |
                      {XL{i_ctrl.op_and}}                      & (i_lhs & i_rhs) |
                      {XL{i_ctrl.shift || i_ctrl.rotate}}      & shf_result      |
                      {XL{i_ctrl.compare}}                     & {{(XL-1){1'b0}}, o_lt};

endmodule

// ==== hw/exec_decode.sv ====
// Micro-op decode for the execute stage
// ALU operation selects and branch condition one-hots
`timescale 1ns/1ns

module exec_decode (
    input  exec_pkg::uop_t      i_uop,
    input  exec_pkg::fu_t       i_fu,
    output exec_pkg::alu_ctrl_t o_alu_ctrl,
    output exec_pkg::cond_sel_t o_cond_sel
);

    logic fu_alu;
    logic fu_cfu;
    logic cfu_cond;

    assign fu_alu   = i_fu[exec_pkg::FU_ALU];
    assign fu_cfu   = i_fu[exec_pkg::FU_CFU];
    assign cfu_cond = fu_cfu && (i_uop[4:3] == 2'b00);   // Conditional branch group

    // ------------------------------------------------------------------------
    // Branch conditions
    // ------------------------------------------------------------------------
    assign o_cond_sel.beq  = fu_cfu && (i_uop == exec_pkg::CFU_BEQ);
    assign o_cond_sel.bne  = fu_cfu && (i_uop == exec_pkg::CFU_BNE);
    assign o_cond_sel.blt  = fu_cfu && (i_uop == exec_pkg::CFU_BLT);
    assign o_cond_sel.bge  = fu_cfu && (i_uop == exec_pkg::CFU_BGE);
    assign o_cond_sel.bltu = fu_cfu && (i_uop == exec_pkg::CFU_BLTU);
    assign o_cond_sel.bgeu = fu_cfu && (i_uop == exec_pkg::CFU_BGEU);

    // ------------------------------------------------------------------------
    // ALU controls
    // ------------------------------------------------------------------------
    assign o_alu_ctrl.op_add = fu_alu && (i_uop == exec_pkg::ALU_ADD);
    assign o_alu_ctrl.op_sub = fu_alu && (i_uop == exec_pkg::ALU_SUB);
    assign o_alu_ctrl.op_xor = fu_alu && (i_uop == exec_pkg::ALU_XOR);
    assign o_alu_ctrl.op_or  = fu_alu && (i_uop == exec_pkg::ALU_OR);
    assign o_alu_ctrl.op_and = fu_alu && (i_uop == exec_pkg::ALU_AND);

    assign o_alu_ctrl.shift       = fu_alu && (i_uop == exec_pkg::ALU_SLL ||
                                               i_uop == exec_pkg::ALU_SRL ||
                                               i_uop == exec_pkg::ALU_SRA);
    assign o_alu_ctrl.rotate      = fu_alu && (i_uop == exec_pkg::ALU_ROR);
    assign o_alu_ctrl.shift_left  = fu_alu && (i_uop == exec_pkg::ALU_SLL);
    assign o_alu_ctrl.shift_arith = fu_alu && (i_uop == exec_pkg::ALU_SRA);

    // Branches reuse the comparator, nothing else
    assign o_alu_ctrl.compare     = fu_alu && (i_uop == exec_pkg::ALU_SLT ||
                                               i_uop == exec_pkg::ALU_SLTU) ||
                                    cfu_cond;
    assign o_alu_ctrl.is_unsigned = fu_alu && (i_uop == exec_pkg::ALU_SLTU) ||
                                    o_cond_sel.bltu || o_cond_sel.bgeu;

endmodule

// ==== hw/exec_pipe_reg.sv ====
// Pipeline register with valid/busy handshake and flush
// Single entry, payload type set by the instantiating module
`timescale 1ns/1ns

module exec_pipe_reg #(
    parameter type PAYLOAD_T = exec_pkg::xlen_t
) (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     i_flush,
    input  logic     i_load,      // New item offered
    input  PAYLOAD_T i_data,
    input  logic     i_busy,      // Downstream stall
    output logic     o_busy,
    output logic     o_valid,
    output PAYLOAD_T o_data
);

    assign o_busy = o_valid && i_busy;   // Holding an item nobody takes

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            if (i_flush) begin
                o_valid <= 1'b0;         // Flush wins over a new item
            end else if (!o_busy) begin
                o_valid <= i_load;
            end
            if (i_load && !o_busy) begin
                o_data <= i_data;        // Otherwise hold last payload
            end
        end
    end

endmodule

// ==== hw/exec_pkg.sv ====
// Shared definitions for the execute stage
// Widths, micro-op codes, unit select bits and the stage payload structs
package exec_pkg;

    // ------------------------------------------------------------------------
    // Widths and base types
    // ------------------------------------------------------------------------
    localparam int XLEN         = 32;        // Data width
    localparam int TRAP_CAUSE_W = 6;         // Trap cause width

    typedef logic [XLEN-1:0] xlen_t;         // One data word
    typedef logic [4:0]      reg_addr_t;     // Register index
    typedef logic [4:0]      uop_t;          // Micro-op code
    typedef logic [3:0]      fu_t;           // One-hot unit select

    // Unit select bit positions
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;
    localparam int FU_CSR = 3;

    // ------------------------------------------------------------------------
    // Micro-op codes, meaning depends on the selected unit
    // ------------------------------------------------------------------------
    localparam uop_t ALU_ADD  = 5'b00000;
    localparam uop_t ALU_SUB  = 5'b00001;
    localparam uop_t ALU_XOR  = 5'b00010;
    localparam uop_t ALU_OR   = 5'b00011;
    localparam uop_t ALU_AND  = 5'b00100;
    localparam uop_t ALU_SLL  = 5'b00101;
    localparam uop_t ALU_SRL  = 5'b00110;
    localparam uop_t ALU_SRA  = 5'b00111;
    localparam uop_t ALU_ROR  = 5'b01000;
    localparam uop_t ALU_SLT  = 5'b01001;
    localparam uop_t ALU_SLTU = 5'b01010;

    localparam uop_t CFU_BEQ       = 5'b00001;   // Conditionals, top bits 00
    localparam uop_t CFU_BNE       = 5'b00010;
    localparam uop_t CFU_BLT       = 5'b00011;
    localparam uop_t CFU_BGE       = 5'b00100;
    localparam uop_t CFU_BLTU      = 5'b00101;
    localparam uop_t CFU_BGEU      = 5'b00110;
    localparam uop_t CFU_NOT_TAKEN = 5'b01000;   // Resolved branch outcomes
    localparam uop_t CFU_TAKEN     = 5'b01001;
    localparam uop_t CFU_JALI      = 5'b10000;   // Jumps, top bits 10
    localparam uop_t CFU_JALR      = 5'b10001;
    localparam uop_t CFU_JMP       = 5'b10010;

    localparam int LSU_LOAD_BIT  = 3;            // Uop bit flags for LSU ops
    localparam int LSU_STORE_BIT = 4;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        reg_addr_t   rd;       // Destination, or trap cause when trapping
        xlen_t       opr_a;
        xlen_t       opr_b;
        xlen_t       opr_c;
        uop_t        uop;
        fu_t         fu;
        logic        trap;     // Upstream trap
        logic [1:0]  size;     // Instruction size
        logic [31:0] instr;
    } s2_issue_t;

    typedef struct packed {
        reg_addr_t   rd;
        xlen_t       opr_a;    // Unit result
        uop_t        uop;      // Branch outcome for conditionals
        fu_t         fu;
        logic        trap;
        logic [1:0]  size;
        logic [31:0] instr;
    } s3_ctrl_t;

    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_xor;
        logic op_or;
        logic op_and;
        logic shift;           // Any of sll / srl / sra
        logic rotate;
        logic shift_left;
        logic shift_arith;
        logic compare;         // Adder runs as subtract
        logic is_unsigned;
    } alu_ctrl_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
    } cond_sel_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     wdata;
        logic      load;       // Result not ready until memory returns
        logic      csr;
    } fwd_t;

endpackage

// ==== hw/exec_result_select.sv ====
// Result selection for the execute stage
// Branch resolution, jump target, operand A/B muxing, load enables, forwarding
`timescale 1ns/1ns

module exec_result_select (
    input  exec_pkg::s2_issue_t i_s2,
    input  logic                i_accept,
    input  exec_pkg::cond_sel_t i_cond_sel,
    input  exec_pkg::xlen_t     i_alu_result,
    input  exec_pkg::xlen_t     i_sum,
    input  logic                i_lt,
    input  logic                i_eq,
    output exec_pkg::s3_ctrl_t  o_ctrl_next,
    output exec_pkg::xlen_t     o_opr_b_next,
    output logic                o_ctrl_load,
    output logic                o_opr_b_load,
    output exec_pkg::fwd_t      o_fwd
);

    localparam int XL = exec_pkg::XLEN;

    logic                                fu_alu;
    logic                                fu_lsu;
    logic                                fu_cfu;
    logic                                fu_csr;
    logic                                cfu_cond;
    logic                                cfu_jalr;
    logic                                taken;
    logic                                lsu_load;
    logic                                lsu_store;
    exec_pkg::xlen_t                     cfu_target;
    exec_pkg::xlen_t                     opr_a_next;
    logic [exec_pkg::TRAP_CAUSE_W-1:0]   trap_cause;

    assign fu_alu    = i_s2.fu[exec_pkg::FU_ALU];
    assign fu_lsu    = i_s2.fu[exec_pkg::FU_LSU];
    assign fu_cfu    = i_s2.fu[exec_pkg::FU_CFU];
    assign fu_csr    = i_s2.fu[exec_pkg::FU_CSR];
    assign lsu_load  = fu_lsu && i_s2.uop[exec_pkg::LSU_LOAD_BIT];
    assign lsu_store = fu_lsu && i_s2.uop[exec_pkg::LSU_STORE_BIT];

    // ------------------------------------------------------------------------
    // Control flow
    // ------------------------------------------------------------------------
    assign cfu_cond = fu_cfu && (i_s2.uop[4:3] == 2'b00);
    assign cfu_jalr = fu_cfu && (i_s2.uop == exec_pkg::CFU_JALR);

    // bge/bgeu share !lt, signedness chosen in decode
    assign taken = i_cond_sel.beq  &&  i_eq ||
                   i_cond_sel.bne  && !i_eq ||
                   i_cond_sel.blt  &&  i_lt ||
                   i_cond_sel.bltu &&  i_lt ||
                   i_cond_sel.bge  && !i_lt ||
                   i_cond_sel.bgeu && !i_lt;

    assign cfu_target = cfu_jalr ? {i_sum[XL-1:1], 1'b0} :      // rs1 + imm
                                   {i_s2.opr_c[XL-1:1], 1'b0};  // Precomputed target

    // ------------------------------------------------------------------------
    // Operands and register inputs
    // ------------------------------------------------------------------------
    assign opr_a_next = {XL{fu_alu}} & i_alu_result |
                        {XL{fu_lsu}} & i_sum        |   // Effective address
                        {XL{fu_cfu}} & cfu_target   |
                        {XL{fu_csr}} & i_s2.opr_a;

    assign trap_cause   = {1'b0, i_s2.rd};               // Cause rides in rd
    assign o_opr_b_next = i_s2.trap ? exec_pkg::xlen_t'(trap_cause) : i_s2.opr_c;

    assign o_ctrl_next.rd    = i_s2.rd;
    assign o_ctrl_next.opr_a = opr_a_next;
    assign o_ctrl_next.uop   = cfu_cond ? (taken ? exec_pkg::CFU_TAKEN
                                                 : exec_pkg::CFU_NOT_TAKEN)
                                        : i_s2.uop;
    assign o_ctrl_next.fu    = i_s2.fu;
    assign o_ctrl_next.trap  = i_s2.trap;
    assign o_ctrl_next.size  = i_s2.size;
    assign o_ctrl_next.instr = i_s2.instr;

    assign o_ctrl_load  = i_accept;
    assign o_opr_b_load = i_accept && (lsu_store || fu_csr || i_s2.trap); // B only when used

    // Forwarding back to decode
    assign o_fwd.rd    = i_s2.rd;
    assign o_fwd.wdata = opr_a_next;
    assign o_fwd.load  = lsu_load;
    assign o_fwd.csr   = fu_csr;

endmodule

// ==== hw/exec_stage.sv ====
// Execute stage top level
// Decode, ALU, result select and the control / operand-B registers
`timescale 1ns/1ns

module exec_stage (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  exec_pkg::s2_issue_t i_s2,
    input  logic                i_s2_valid,
    output logic                o_s2_busy,
    input  logic                i_flush,
    output exec_pkg::fwd_t      o_fwd,
    output exec_pkg::s3_ctrl_t  o_s3,
    output exec_pkg::xlen_t     o_s3_opr_b,
    output logic                o_s3_valid,
    input  logic                i_s3_busy
);

    exec_pkg::alu_ctrl_t alu_ctrl;
    exec_pkg::cond_sel_t cond_sel;
    exec_pkg::xlen_t     alu_result;
    exec_pkg::xlen_t     alu_sum;
    logic                alu_lt;
    logic                alu_eq;
    logic                accept;
    exec_pkg::s3_ctrl_t  ctrl_next;
    exec_pkg::xlen_t     opr_b_next;
    logic                ctrl_load;
    logic                opr_b_load;

    assign accept = i_s2_valid && !o_s2_busy;   // Handshake on this edge

    exec_decode i_decode (
        .i_uop      (i_s2.uop),
        .i_fu       (i_s2.fu),
        .o_alu_ctrl (alu_ctrl),
        .o_cond_sel (cond_sel)
    );

    exec_alu i_alu (
        .i_ctrl   (alu_ctrl),
        .i_lhs    (i_s2.opr_a),
        .i_rhs    (i_s2.opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exec_result_select i_result_select (
        .i_s2         (i_s2),
        .i_accept     (accept),
        .i_cond_sel   (cond_sel),
        .i_alu_result (alu_result),
        .i_sum        (alu_sum),
        .i_lt         (alu_lt),
        .i_eq         (alu_eq),
        .o_ctrl_next  (ctrl_next),
        .o_opr_b_next (opr_b_next),
        .o_ctrl_load  (ctrl_load),
        .o_opr_b_load (opr_b_load),
        .o_fwd        (o_fwd)
    );

    // ------------------------------------------------------------------------
    // Output registers, control plus operand A and a separate operand B
    // ------------------------------------------------------------------------
    exec_pipe_reg #(
        .PAYLOAD_T (exec_pkg::s3_ctrl_t)
    ) i_ctrl_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_load   (ctrl_load),
        .i_data   (ctrl_next),
        .i_busy   (i_s3_busy),
        .o_busy   (o_s2_busy),     // Stage stalls only on back-pressure
        .o_valid  (o_s3_valid),
        .o_data   (o_s3)
    );

    exec_pipe_reg #(
        .PAYLOAD_T (exec_pkg::xlen_t)
    ) i_opr_b_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_load   (opr_b_load),
        .i_data   (opr_b_next),
        .i_busy   (i_s3_busy),
        .o_busy   (),
        .o_valid  (),
        .o_data   (o_s3_opr_b)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=tb_exec_stage
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f verilog.f \
    --Mdir obj_dir -o "$TOP"

status=0
"./obj_dir/$TOP" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG" || [ "$status" -ne 0 ]; then
    echo "Simulation FAILED (exit status $status), see $LOG"
    exit 1
fi
echo "Simulation finished without errors"

// ==== testbench/tb_exec_stage.sv ====
// Testbench for the execute stage
// Clock, reset, watchdog, value check, reference model and directed tests
`timescale 1ns/1ns

module tb_exec_stage;

    localparam int RESET_CYCLES    = 16;
    localparam int MAX_ITEMS       = 64;                 // Upper bound, about 51 items issued
    localparam int CYCLES_PER_ITEM = 31;                 // Worst case incl. back-pressure
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ITEMS * CYCLES_PER_ITEM;

    logic                g_clk;
    logic                g_resetn;
    exec_pkg::s2_issue_t s2_item;
    logic                s2_valid;
    logic                s2_busy;
    logic                flush;
    exec_pkg::fwd_t      fwd;
    exec_pkg::s3_ctrl_t  s3_ctrl;
    exec_pkg::xlen_t     s3_opr_b;
    logic                s3_valid;
    logic                s3_busy;
    exec_pkg::xlen_t     exp_opr_b;                      // Operand B register model

    exec_stage i_exec_stage (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2       (s2_item),
        .i_s2_valid (s2_valid),
        .o_s2_busy  (s2_busy),
        .i_flush    (flush),
        .o_fwd      (fwd),
        .o_s3       (s3_ctrl),
        .o_s3_opr_b (s3_opr_b),
        .o_s3_valid (s3_valid),
        .i_s3_busy  (s3_busy)
    );

    always #10 g_clk = ~g_clk;                           // 20 ns period

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge g_clk);
        $display("TIMEOUT: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "Run stopped by the watchdog");
    end

    // ------------------------------------------------------------------------
    // Check and reference model
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%h expected 0x%h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic exec_pkg::xlen_t model_alu(input exec_pkg::uop_t uop,
                                                  input exec_pkg::xlen_t a,
                                                  input exec_pkg::xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];                                     // Low 5 bits only
        case (uop)
            exec_pkg::ALU_ADD:  return a + b;
            exec_pkg::ALU_SUB:  return a - b;
            exec_pkg::ALU_XOR:  return a ^ b;
            exec_pkg::ALU_OR:   return a | b;
            exec_pkg::ALU_AND:  return a & b;
            exec_pkg::ALU_SLL:  return a << sh;
            exec_pkg::ALU_SRL:  return a >> sh;
            exec_pkg::ALU_SRA:  return $signed(a) >>> sh;
            exec_pkg::ALU_ROR:  return (a >> sh) | (a << (6'd32 - {1'b0, sh}));
            exec_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            exec_pkg::ALU_SLTU: return {31'd0, a < b};
            default:            return '0;
        endcase
    endfunction

    function automatic logic model_taken(input exec_pkg::uop_t uop,
                                         input exec_pkg::xlen_t a, input exec_pkg::xlen_t b);
        case (uop)
            exec_pkg::CFU_BEQ:  return a == b;
            exec_pkg::CFU_BNE:  return a != b;
            exec_pkg::CFU_BLT:  return $signed(a) < $signed(b);
            exec_pkg::CFU_BGE:  return $signed(a) >= $signed(b);
            exec_pkg::CFU_BLTU: return a < b;
            default:            return a >= b;           // bgeu
        endcase
    endfunction

    function automatic exec_pkg::s3_ctrl_t model_s3(input exec_pkg::s2_issue_t it);
        exec_pkg::s3_ctrl_t e;
        e       = '{rd: it.rd, opr_a: it.opr_a, uop: it.uop, fu: it.fu, trap: it.trap,
                    size: it.size, instr: it.instr};     // CSR keeps opr_a
        if (it.fu[exec_pkg::FU_ALU]) begin
            e.opr_a = model_alu(it.uop, it.opr_a, it.opr_b);
        end else if (it.fu[exec_pkg::FU_LSU]) begin
            e.opr_a = it.opr_a + it.opr_b;               // Effective address
        end else if (it.fu[exec_pkg::FU_CFU]) begin
            if (it.uop[4:3] == 2'b00) begin
                e.uop   = model_taken(it.uop, it.opr_a, it.opr_b) ? exec_pkg::CFU_TAKEN
                                                                  : exec_pkg::CFU_NOT_TAKEN;
                e.opr_a = it.opr_c & ~32'd1;
            end else if (it.uop == exec_pkg::CFU_JALR) begin
                e.opr_a = (it.opr_a + it.opr_b) & ~32'd1;
            end else begin
                e.opr_a = it.opr_c & ~32'd1;             // jal / jmp target
            end
        end
        return e;
    endfunction

    function automatic exec_pkg::xlen_t model_opr_b(input exec_pkg::s2_issue_t it,
                                                    input exec_pkg::xlen_t prev);
        if (it.trap) begin
            return {27'd0, it.rd};                       // Cause zero-extended
        end else if ((it.fu[exec_pkg::FU_LSU] && it.uop[exec_pkg::LSU_STORE_BIT]) ||
                     it.fu[exec_pkg::FU_CSR]) begin
            return it.opr_c;
        end
        return prev;                                     // Register holds
    endfunction

    function automatic exec_pkg::s2_issue_t random_item(input exec_pkg::uop_t uop,
                                                        input int fu_pos);
        exec_pkg::s2_issue_t it;
        it.rd         = 5'($urandom());
        it.opr_a      = $urandom();
        it.opr_b      = $urandom();
        it.opr_c      = $urandom();
        it.uop        = uop;
        it.fu         = '0;
        it.fu[fu_pos] = 1'b1;                            // One-hot unit
        it.trap       = 1'b0;
        it.size       = 2'($urandom());
        it.instr      = $urandom();
        return it;
    endfunction

    // ------------------------------------------------------------------------
    // Item handshake
    // ------------------------------------------------------------------------
    task automatic check_s3(input exec_pkg::s3_ctrl_t e);
        check_value("o_s3.rd",    32'(s3_ctrl.rd),    32'(e.rd));
        check_value("o_s3.opr_a", s3_ctrl.opr_a,      e.opr_a);
        check_value("o_s3.uop",   32'(s3_ctrl.uop),   32'(e.uop));
        check_value("o_s3.fu",    32'(s3_ctrl.fu),    32'(e.fu));
        check_value("o_s3.trap",  32'(s3_ctrl.trap),  32'(e.trap));
        check_value("o_s3.size",  32'(s3_ctrl.size),  32'(e.size));
        check_value("o_s3.instr", s3_ctrl.instr,      e.instr);
    endtask

    task automatic present_item(input exec_pkg::s2_issue_t item);
        exec_pkg::s3_ctrl_t e;
        e = model_s3(item);
        @(posedge g_clk);
        s2_item  <= item;
        s2_valid <= 1'b1;
        @(negedge g_clk);                                // Forwarding is combinational
        check_value("o_fwd.rd",    32'(fwd.rd), 32'(item.rd));
        check_value("o_fwd.wdata", fwd.wdata,   e.opr_a);
        check_value("o_fwd.load",  32'(fwd.load),
                    32'(item.fu[exec_pkg::FU_LSU] && item.uop[exec_pkg::LSU_LOAD_BIT]));
        check_value("o_fwd.csr",   32'(fwd.csr), 32'(item.fu[exec_pkg::FU_CSR]));
        while (s2_busy) @(negedge g_clk);
        @(posedge g_clk);                                // Accepted on this edge
        s2_valid <= 1'b0;
    endtask

    task automatic wait_output();
        @(negedge g_clk);
        while (!s3_valid) @(negedge g_clk);
    endtask

    task automatic run_item(input exec_pkg::s2_issue_t item);
        exp_opr_b = model_opr_b(item, exp_opr_b);
        present_item(item);
        wait_output();
        check_s3(model_s3(item));
        check_value("o_s3_opr_b", s3_opr_b, exp_opr_b);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge g_clk);
        check_value("o_s3_valid", 32'(s3_valid), 32'd0);
        check_value("o_s2_busy",  32'(s2_busy),  32'd0);
        check_value("o_s3.opr_a", s3_ctrl.opr_a, 32'd0);
        check_value("o_s3.instr", s3_ctrl.instr, 32'd0);
        check_value("o_s3_opr_b", s3_opr_b,      32'd0);
    endtask

    task automatic test_alu_ops();
        int code;
        for (code = 0; code <= 10; code++) begin         // ALU_ADD .. ALU_SLTU
            run_item(random_item(exec_pkg::uop_t'(code), exec_pkg::FU_ALU));
        end
    endtask

    task automatic test_branches();
        exec_pkg::uop_t      codes [6];
        exec_pkg::xlen_t     lhs [5];
        exec_pkg::xlen_t     rhs [5];
        exec_pkg::xlen_t     same;
        exec_pkg::s2_issue_t item;
        int                  c;
        int                  k;
        codes = '{exec_pkg::CFU_BEQ, exec_pkg::CFU_BNE, exec_pkg::CFU_BLT,
                  exec_pkg::CFU_BGE, exec_pkg::CFU_BLTU, exec_pkg::CFU_BGEU};
        same  = $urandom();
        lhs   = '{same, 32'd5, 32'd9, 32'h8000_0010, 32'h0000_0010};
        rhs   = '{same, 32'd9, 32'd5, 32'h0000_0010, 32'hffff_fff0}; // Signed vs unsigned
        for (c = 0; c < 6; c++) begin
            for (k = 0; k < 5; k++) begin
                item       = random_item(codes[c], exec_pkg::FU_CFU);
                item.opr_a = lhs[k];
                item.opr_b = rhs[k];
                run_item(item);
            end
        end
        run_item(random_item(exec_pkg::CFU_JALI, exec_pkg::FU_CFU));
        run_item(random_item(exec_pkg::CFU_JALR, exec_pkg::FU_CFU));
        run_item(random_item(exec_pkg::CFU_JMP,  exec_pkg::FU_CFU));
    endtask

    task automatic test_lsu_csr();
        run_item(random_item(5'b01000, exec_pkg::FU_LSU));   // Load
        run_item(random_item(5'b10000, exec_pkg::FU_LSU));   // Store, B takes opr_c
        run_item(random_item(5'b00001, exec_pkg::FU_CSR));
    endtask

    task automatic test_trap();
        exec_pkg::s2_issue_t item;
        item      = random_item(exec_pkg::ALU_ADD, exec_pkg::FU_ALU);
        item.trap = 1'b1;
        run_item(item);
    endtask

    task automatic test_back_pressure();
        exec_pkg::s2_issue_t first;
        exec_pkg::s2_issue_t second;
        first  = random_item(exec_pkg::ALU_XOR, exec_pkg::FU_ALU);
        second = random_item(exec_pkg::ALU_SUB, exec_pkg::FU_ALU);
        @(posedge g_clk);
        s3_busy <= 1'b1;                                 // Downstream stalls
        exp_opr_b = model_opr_b(first, exp_opr_b);
        present_item(first);
        s2_item  <= second;                              // Offered during the stall
        s2_valid <= 1'b1;
        wait_output();
        repeat (4) begin
            check_value("o_s2_busy",  32'(s2_busy),  32'd1);
            check_value("o_s3_valid", 32'(s3_valid), 32'd1);
            check_s3(model_s3(first));
            check_value("o_s3_opr_b", s3_opr_b, exp_opr_b);
            @(negedge g_clk);
        end
        @(posedge g_clk);
        s3_busy <= 1'b0;                                 // Release
        exp_opr_b = model_opr_b(second, exp_opr_b);
        @(negedge g_clk);
        while (s2_busy) @(negedge g_clk);
        @(posedge g_clk);
        s2_valid <= 1'b0;
        wait_output();
        check_s3(model_s3(second));
        check_value("o_s3_opr_b", s3_opr_b, exp_opr_b);
    endtask

    task automatic test_flush();
        exec_pkg::s2_issue_t item;
        item      = random_item(exec_pkg::ALU_OR, exec_pkg::FU_ALU);
        exp_opr_b = model_opr_b(item, exp_opr_b);
        present_item(item);
        flush   <= 1'b1;                                 // Seen on the next edge
        s3_busy <= 1'b1;                                 // Item would otherwise be held
        @(negedge g_clk);
        check_value("o_s3_valid", 32'(s3_valid), 32'd1);
        @(posedge g_clk);
        flush <= 1'b0;
        @(negedge g_clk);
        check_value("o_s3_valid", 32'(s3_valid), 32'd0);
        check_value("o_s2_busy",  32'(s2_busy),  32'd0);
        @(posedge g_clk);
        s3_busy <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(15));                             // Fixed seed
        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        s2_item    = '0;
        s2_valid   = 1'b0;
        flush      = 1'b0;
        s3_busy    = 1'b0;
        exp_opr_b  = '0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        test_reset_state();
        test_alu_ops();
        test_branches();
        test_lsu_csr();
        test_trap();
        test_back_pressure();
        test_flush();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/exec_pkg.sv
hw/exec_decode.sv
hw/exec_alu.sv
hw/exec_result_select.sv
hw/exec_pipe_reg.sv
hw/exec_stage.sv
testbench/tb_exec_stage.sv
